//--- l2_golden.txt
# op addr wdata exp_rdata line_reads line_writes (hex, hex, hex, hex, dec, dec)
# op 0 read, 1 write, 2 index-init, 3 index-inv-wb, 4 hit-inv-wb; exp_rdata used for reads only
0 0005 00000000 5a5a0005 1 0
0 0007 00000000 5a5a0007 0 0
1 0006 deadbeef 00000000 0 0
0 0006 00000000 deadbeef 0 0
1 0049 11111111 00000000 1 0
0 0088 00000000 5a5a0088 1 0
0 00c8 00000000 5a5a00c8 1 0
0 0108 00000000 5a5a0108 1 0
0 0148 00000000 5a5a0148 1 1
0 008a 00000000 5a5a008a 0 0
0 0049 00000000 11111111 1 0
0 004a 00000000 5a5a004a 0 0
0 00c8 00000000 5a5a00c8 1 0
1 020d cafef00d 00000000 1 0
0 020d 00000000 cafef00d 0 0
0 020e 00000000 5a5a020e 0 0
3 000c 00000000 00000000 0 1
0 020d 00000000 cafef00d 1 0
1 020d 0badc0de 00000000 0 0
4 020c 00000000 00000000 0 1
0 020d 00000000 0badc0de 1 0
1 020d 77777777 00000000 0 0
2 000d 00000000 00000000 0 0
0 020d 00000000 0badc0de 1 0
4 0300 00000000 00000000 0 0
3 0004 00000000 00000000 0 1
0 0006 00000000 deadbeef 1 0

//--- filelist.f
l2_pkg.sv
l2_ifs.sv
l2_plru.sv
l2_data_array.sv
l2_tag_dirty.sv
l2_ctrl.sv
l2_cache_top.sv
tb_clk_gen.sv
tb_l2_cache.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/tb_l2_cache
	out=$$(./obj_dir/tb_l2_cache); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

obj_dir/tb_l2_cache: $(SRCS) filelist.f
	verilator --binary --top-module tb_l2_cache -f filelist.f -o tb_l2_cache

clean:
	rm -rf obj_dir

//--- tb_l2_cache.sv
`default_nettype none

module tb_l2_cache;
    import l2_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int CYCLES_PER_TXN = 64;

    typedef struct packed {
        logic [2:0] op;
        addr_t      addr;
        word_t      wdata;
        word_t      rdata;
        int         rd;
        int         wr;
    } txn_t;

    logic    clk;
    logic    rstn;
    logic    cpu_req_i;
    cpu_op_e cpu_op_i;
    addr_t   cpu_addr_i;
    word_t   cpu_wdata_i;
    logic    cpu_addr_ok_o;
    logic    cpu_data_ok_o;
    word_t   cpu_rdata_o;
    logic    mem_rd_req_o;
    logic    mem_wr_req_o;
    addr_t   mem_addr_o;
    line_t   mem_wline_o;
    logic    mem_rdy_o;
    logic    mem_addr_ok_i = 1'b0;
    logic    mem_data_ok_i = 1'b0;
    line_t   mem_rline_i   = '0;

    txn_t        golden [$];
    word_t       mem_words [int];   // only lines written back live here
    int          rd_cnt       = 0;
    int          wr_cnt       = 0;
    logic        want_addr    = 1'b0;
    logic        want_data    = 1'b0;
    addr_t       rd_line_addr = '0;
    int          wait_cnt     = 0;
    logic [31:0] rand_state   = 32'h993a;
    int          cycle_cnt    = 0;
    int          cycle_limit  = RESET_CYCLES;

    tb_clk_gen #(.PERIOD(4)) u_clk_gen (.clk_o(clk));

    l2_cache_top #(
        .INDEX_WIDTH  (4),
        .OFFSET_WIDTH (2)
    ) u_l2_cache_top (
        .clk           (clk),
        .rstn          (rstn),
        .cpu_req_i     (cpu_req_i),
        .cpu_op_i      (cpu_op_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_wdata_i   (cpu_wdata_i),
        .cpu_addr_ok_o (cpu_addr_ok_o),
        .cpu_data_ok_o (cpu_data_ok_o),
        .cpu_rdata_o   (cpu_rdata_o),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_wr_req_o  (mem_wr_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wline_o   (mem_wline_o),
        .mem_rdy_o     (mem_rdy_o),
        .mem_addr_ok_i (mem_addr_ok_i),
        .mem_data_ok_i (mem_data_ok_i),
        .mem_rline_i   (mem_rline_i)
    );

    function automatic logic [31:0] next_rand();
        rand_state ^= rand_state << 13;
        rand_state ^= rand_state >> 17;
        rand_state ^= rand_state << 5;
        return rand_state;
    endfunction

    function automatic word_t mem_word(input int a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return 32'h5a5a0000 | a; // untouched memory
    endfunction

    function automatic line_t line_at(input addr_t base);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i*WORD_W +: WORD_W] = mem_word(int'(base) + i);
        end
        return l;
    endfunction

    ////////////////////////////////////////
    // memory model
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn) begin
            if (mem_wr_req_o && mem_addr_ok_i) begin
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    mem_words[int'(mem_addr_o) + i] = mem_wline_o[i*WORD_W +: WORD_W];
                end
                wr_cnt++;
            end
            if (mem_rd_req_o && mem_addr_ok_i) begin
                rd_line_addr = mem_addr_o;
                rd_cnt++;
            end
            want_addr = (mem_wr_req_o || mem_rd_req_o) && !mem_addr_ok_i;
            want_data = mem_rdy_o && !mem_data_ok_i;
        end else begin
            want_addr = 1'b0;
            want_data = 1'b0;
        end
    end

    always @(posedge clk) begin
        mem_addr_ok_i <= 1'b0;
        mem_data_ok_i <= 1'b0;
        if (!rstn) begin
            wait_cnt = 0;
        end else if (want_addr || want_data) begin
            if (wait_cnt == 0) begin
                if (want_addr) begin
                    mem_addr_ok_i <= 1'b1;
                end else begin
                    mem_data_ok_i <= 1'b1;
                    mem_rline_i   <= line_at(rd_line_addr);
                end
                wait_cnt = int'(next_rand() & 32'h3); // 0 to 3 idle cycles
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, the DUT did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    ////////////////////////////////////////
    // checks and transactions
    ////////////////////////////////////////
    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_golden();
        int         fd;
        int         n;
        string      text;
        logic [2:0] op;
        addr_t      addr;
        word_t      wdata;
        word_t      rdata;
        int         rd;
        int         wr;
        fd = $fopen("l2_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open l2_golden.txt");
            $display("Checks failed");
            $fatal(1, "missing stimulus file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0 && text.getc(0) != "#") begin
                    n = $sscanf(text, "%h %h %h %h %d %d", op, addr, wdata, rdata, rd, wr);
                    if (n == 6) begin
                        golden.push_back('{op, addr, wdata, rdata, rd, wr});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic do_access(input txn_t t);
        int    rd_before;
        int    wr_before;
        int    latency;
        logic  fixed_lat;
        word_t got;
        rd_before = rd_cnt;
        wr_before = wr_cnt;
        // hits and index-init answer one cycle after acceptance
        fixed_lat = (cpu_op_e'(t.op) == OP_IDX_INIT)
                 || ((cpu_op_e'(t.op) == OP_READ || cpu_op_e'(t.op) == OP_WRITE)
                     && t.rd == 0 && t.wr == 0);
        @(posedge clk);
        cpu_req_i   <= 1'b1;
        cpu_op_i    <= cpu_op_e'(t.op);
        cpu_addr_i  <= t.addr;
        cpu_wdata_i <= t.wdata;
        @(negedge clk);
        while (!cpu_addr_ok_o) @(negedge clk);
        @(posedge clk);
        cpu_req_i <= 1'b0;
        latency = 1;
        @(negedge clk);
        while (!cpu_data_ok_o) begin
            @(negedge clk);
            latency++;
        end
        got = cpu_rdata_o;
        @(posedge clk); // let the memory model settle its counters
        if (cpu_op_e'(t.op) == OP_READ) begin
            check_eq("cpu_rdata_o", got, t.rdata);
        end
        if (fixed_lat) begin
            check_eq("cpu_data_ok_o latency", latency, 1);
        end
        check_eq("mem_rd_req_o count", rd_cnt - rd_before, t.rd);
        check_eq("mem_wr_req_o count", wr_cnt - wr_before, t.wr);
    endtask

    initial begin
        rstn        = 1'b0;
        cpu_req_i   = 1'b0;
        cpu_op_i    = OP_READ;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        load_golden();
        cycle_limit = golden.size() * CYCLES_PER_TXN + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        foreach (golden[i]) begin
            do_access(golden[i]);
        end
        if (golden.size() > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("the golden file held no transactions");
            $display("Checks failed");
            $fatal(1, "nothing was tested");
        end
    end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o; // free running

endmodule

`default_nettype wire

//--- l2_cache_top.sv
`default_nettype none

module l2_cache_top #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2   // fixed by line_t
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cpu_req_i,
    input  l2_pkg::cpu_op_e cpu_op_i,
    input  l2_pkg::addr_t   cpu_addr_i,
    input  l2_pkg::word_t   cpu_wdata_i,
    output logic            cpu_addr_ok_o,
    output logic            cpu_data_ok_o,
    output l2_pkg::word_t   cpu_rdata_o,
    output logic            mem_rd_req_o,
    output logic            mem_wr_req_o,
    output l2_pkg::addr_t   mem_addr_o,
    output l2_pkg::line_t   mem_wline_o,
    output logic            mem_rdy_o,
    input  logic            mem_addr_ok_i,
    input  logic            mem_data_ok_i,
    input  l2_pkg::line_t   mem_rline_i
);

    tag_if  #(.INDEX_WIDTH(INDEX_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) tag_bus ();
    data_if #(.INDEX_WIDTH(INDEX_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) data_bus ();
    plru_if #(.INDEX_WIDTH(INDEX_WIDTH))                              plru_bus ();

    l2_ctrl #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .cpu_req_i     (cpu_req_i),
        .cpu_op_i      (cpu_op_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_wdata_i   (cpu_wdata_i),
        .cpu_addr_ok_o (cpu_addr_ok_o),
        .cpu_data_ok_o (cpu_data_ok_o),
        .cpu_rdata_o   (cpu_rdata_o),
        .mem_rd_req_o  (mem_rd_req_o),
        .mem_wr_req_o  (mem_wr_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wline_o   (mem_wline_o),
        .mem_rdy_o     (mem_rdy_o),
        .mem_addr_ok_i (mem_addr_ok_i),
        .mem_data_ok_i (mem_data_ok_i),
        .mem_rline_i   (mem_rline_i),
        .tag_o         (tag_bus.ctrl),
        .data_o        (data_bus.ctrl),
        .plru_o        (plru_bus.ctrl)
    );

    l2_tag_dirty #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_tag (
        .clk   (clk),
        .rstn  (rstn),
        .tag_i (tag_bus.store)
    );

    l2_data_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_data (
        .clk    (clk),
        .data_i (data_bus.store)
    );

    l2_plru #(.INDEX_WIDTH(INDEX_WIDTH)) u_plru (
        .clk    (clk),
        .rstn   (rstn),
        .plru_i (plru_bus.tree)
    );

endmodule

`default_nettype wire

//--- l2_ctrl.sv
`default_nettype none

module l2_ctrl #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cpu_req_i,
    input  l2_pkg::cpu_op_e cpu_op_i,
    input  l2_pkg::addr_t   cpu_addr_i,
    input  l2_pkg::word_t   cpu_wdata_i,
    output logic            cpu_addr_ok_o,
    output logic            cpu_data_ok_o,
    output l2_pkg::word_t   cpu_rdata_o,
    output logic            mem_rd_req_o,
    output logic            mem_wr_req_o,
    output l2_pkg::addr_t   mem_addr_o,
    output l2_pkg::line_t   mem_wline_o,
    output logic            mem_rdy_o,
    input  logic            mem_addr_ok_i,
    input  logic            mem_data_ok_i,
    input  l2_pkg::line_t   mem_rline_i,
    tag_if.ctrl             tag_o,
    data_if.ctrl            data_o,
    plru_if.ctrl            plru_o
);
    import l2_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH;

    ctrl_state_e             state_q;
    ctrl_state_e             state_d;
    cpu_op_e                 req_op;
    addr_t                   req_addr;
    word_t                   req_wdata;
    way_t                    way_q;
    way_t                    way_d;
    way_t                    hit_way;
    way_t                    op_way;
    logic                    hit;
    logic                    accept;
    logic                    is_access;
    logic [OFFSET_WIDTH-1:0] req_off;

    function automatic way_t first_way(way_vec_t v);
        way_t w;
        w = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (v[i]) w = way_t'(i);
        end
        return w;
    endfunction

    assign accept    = cpu_req_i && (state_q == ST_IDLE);
    assign hit       = |tag_o.hit;
    assign hit_way   = first_way(tag_o.hit);
    assign req_off   = req_addr[OFFSET_WIDTH-1:0];
    assign op_way    = way_t'(req_off); // maintenance ops name the way here
    assign is_access = (req_op == OP_READ) || (req_op == OP_WRITE);

    // arrays see the incoming address in idle, the held one afterwards
    assign tag_o.index  = (state_q == ST_IDLE) ? cpu_addr_i[OFFSET_WIDTH +: INDEX_WIDTH]
                                               : req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag_o.tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign tag_o.dsel   = way_q;
    assign data_o.index = tag_o.index;
    assign data_o.offset = req_off;
    assign data_o.wword = req_wdata;
    assign data_o.rline = mem_rline_i;
    assign plru_o.index = tag_o.index;

    assign cpu_addr_ok_o = accept;
    assign cpu_rdata_o   = (state_q == ST_REFILL_WAIT) ? mem_rline_i[req_off*WORD_W +: WORD_W]
                                                       : data_o.word;
    assign mem_addr_o    = (state_q == ST_WRITEBACK) ? tag_o.wb_addr
                         : {req_addr[ADDR_W-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign mem_wline_o   = data_o.line;

    ////////////////////////////////////////
    // main fsm
    ////////////////////////////////////////
    always_comb begin
        state_d        = state_q;
        way_d          = way_q;
        cpu_data_ok_o  = 1'b0;
        mem_rd_req_o   = 1'b0;
        mem_wr_req_o   = 1'b0;
        mem_rdy_o      = 1'b0;
        tag_o.we       = '0;
        tag_o.vclr     = '0;
        tag_o.dset     = 1'b0;
        tag_o.dclr     = 1'b0;
        tag_o.dway     = way_q;
        data_o.we      = '0;
        data_o.refill  = 1'b0;
        data_o.rd_way  = way_q;
        plru_o.use_en  = 1'b0;
        plru_o.use_way = way_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (cpu_op_i == OP_READ || cpu_op_i == OP_WRITE) state_d = ST_LOOKUP;
                    else state_d = ST_OPERATION;
                end
            end
            ST_LOOKUP: begin
                data_o.rd_way = hit_way;
                if (hit) begin
                    plru_o.use_en  = 1'b1;
                    plru_o.use_way = hit_way;
                    cpu_data_ok_o  = 1'b1;
                    if (req_op == OP_WRITE) begin
                        data_o.we[hit_way] = 1'b1;
                        tag_o.dset         = 1'b1;
                        tag_o.dway         = hit_way;
                    end
                    state_d = ST_IDLE;
                end else begin
                    way_d   = plru_o.victim; // victim fixed for the whole miss
                    state_d = ST_CHECK_DIRTY;
                end
            end
            ST_OPERATION: begin
                case (req_op)
                    OP_IDX_INIT: begin
                        tag_o.vclr[op_way] = 1'b1;
                        cpu_data_ok_o      = 1'b1;
                        state_d            = ST_IDLE;
                    end
                    OP_IDX_INV_WB: begin
                        way_d   = op_way;
                        state_d = ST_CHECK_DIRTY;
                    end
                    OP_HIT_INV_WB: begin
                        if (hit) begin
                            way_d   = hit_way;
                            state_d = ST_CHECK_DIRTY;
                        end else begin
                            cpu_data_ok_o = 1'b1; // nothing to drop
                            state_d       = ST_IDLE;
                        end
                    end
                    default: state_d = ST_IDLE;
                endcase
            end
            ST_CHECK_DIRTY: state_d = ST_CHECK_DIRTY1; // dirty read in flight
            ST_CHECK_DIRTY1: begin
                if (tag_o.dirty) begin
                    state_d = ST_WRITEBACK;
                end else if (is_access) begin
                    state_d = ST_REFILL_REQ;
                end else begin
                    tag_o.vclr[way_q] = 1'b1;
                    cpu_data_ok_o     = 1'b1;
                    state_d           = ST_IDLE;
                end
            end
            ST_WRITEBACK: begin
                mem_wr_req_o = 1'b1;
                if (mem_addr_ok_i) begin
                    if (is_access) begin
                        state_d = ST_REFILL_REQ;
                    end else begin
                        tag_o.vclr[way_q] = 1'b1;
                        cpu_data_ok_o     = 1'b1;
                        state_d           = ST_IDLE;
                    end
                end
            end
            ST_REFILL_REQ: begin
                mem_rd_req_o = 1'b1;
                if (mem_addr_ok_i) state_d = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                mem_rdy_o = 1'b1;
                if (mem_data_ok_i) begin
                    data_o.refill     = 1'b1;
                    data_o.we[way_q]  = 1'b1;
                    tag_o.we[way_q]   = 1'b1;
                    tag_o.dclr        = 1'b1;
                    plru_o.use_en     = 1'b1;
                    if (req_op == OP_READ) begin
                        cpu_data_ok_o = 1'b1; // word bypassed from memory
                        state_d       = ST_IDLE;
                    end else begin
                        state_d = ST_REFILL_WRITE;
                    end
                end
            end
            ST_REFILL_WRITE: begin
                data_o.we[way_q] = 1'b1;
                tag_o.dset       = 1'b1;
                cpu_data_ok_o    = 1'b1;
                state_d          = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
            way_q   <= '0;
        end else begin
            state_q <= state_d;
            way_q   <= way_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= cpu_op_i;
            req_addr  <= cpu_addr_i;
            req_wdata <= cpu_wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- l2_tag_dirty.sv
`default_nettype none

module l2_tag_dirty #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic clk,
    input  logic rstn,
    tag_if.store tag_i
);
    import l2_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int SETS  = 1 << INDEX_WIDTH;

    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][SETS];
    logic [TAG_W-1:0]    rd_tag  [NUM_WAYS];
    logic [TAG_W-1:0]    rd_wb_tag;
    logic [NUM_WAYS-1:0] valid_q [SETS];
    logic [NUM_WAYS-1:0] dirty_q [SETS];
    way_vec_t            rd_valid;
    logic                rd_dirty;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_i.we[w]) tag_mem[w][tag_i.index] <= tag_i.tag;
            rd_tag[w] <= tag_mem[w][tag_i.index];
        end
        rd_wb_tag <= tag_mem[tag_i.dsel][tag_i.index]; // victim tag for write-back
    end

    ////////////////////////////////////////
    // valid and dirty bits
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rd_valid <= '0;
            rd_dirty <= 1'b0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (tag_i.we[w]) valid_q[tag_i.index][w] <= 1'b1;
                if (tag_i.vclr[w]) begin
                    valid_q[tag_i.index][w] <= 1'b0;
                    dirty_q[tag_i.index][w] <= 1'b0; // dropped data never written back
                end
            end
            if (tag_i.dset) dirty_q[tag_i.index][tag_i.dway] <= 1'b1;
            if (tag_i.dclr) dirty_q[tag_i.index][tag_i.dway] <= 1'b0;
            rd_valid <= valid_q[tag_i.index];
            rd_dirty <= dirty_q[tag_i.index][tag_i.dsel];
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_i.hit[w] = rd_valid[w] && (rd_tag[w] == tag_i.tag);
        end
    end

    assign tag_i.dirty   = rd_dirty;
    assign tag_i.wb_addr = {rd_wb_tag, tag_i.index, {OFFSET_WIDTH{1'b0}}};

endmodule

`default_nettype wire

//--- l2_data_array.sv
`default_nettype none

module l2_data_array #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic  clk,
    data_if.store data_i
);
    import l2_pkg::*;

    localparam int SETS = 1 << INDEX_WIDTH;

    line_t mem  [NUM_WAYS][SETS];
    line_t rd_q [NUM_WAYS];

    ////////////////////////////////////////
    // write and registered read
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (data_i.we[w]) begin
                if (data_i.refill) begin
                    mem[w][data_i.index] <= data_i.rline;
                end else begin
                    // single word merge
                    mem[w][data_i.index][data_i.offset*WORD_W +: WORD_W] <= data_i.wword;
                end
            end
            rd_q[w] <= mem[w][data_i.index];
        end
    end

    assign data_i.line = rd_q[data_i.rd_way]; // write-back source
    assign data_i.word = data_i.line[data_i.offset*WORD_W +: WORD_W];

endmodule

`default_nettype wire

//--- l2_plru.sv
`default_nettype none

module l2_plru #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic clk,
    input  logic rstn,
    plru_if.tree plru_i
);
    localparam int SETS = 1 << INDEX_WIDTH;

    // [0] root, [1] leaf for ways 0-1, [2] leaf for ways 2-3
    logic [2:0] bits_q [SETS];
    logic [2:0] cur;

    assign cur = bits_q[plru_i.index];

    // follow the pointers down the tree
    assign plru_i.victim = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                bits_q[s] <= '0;
            end
        end else if (plru_i.use_en) begin
            bits_q[plru_i.index][0] <= ~plru_i.use_way[1]; // point at the other pair
            if (plru_i.use_way[1]) begin
                bits_q[plru_i.index][2] <= ~plru_i.use_way[0];
            end else begin
                bits_q[plru_i.index][1] <= ~plru_i.use_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- l2_ifs.sv
`default_nettype none

// tag, valid and dirty storage
interface tag_if #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
);
    import l2_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH;

    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_W-1:0]       tag;     // lookup tag, also written on refill
    way_vec_t               we;      // tag write, sets valid
    way_vec_t               vclr;    // clears valid and dirty
    logic                   dset;
    logic                   dclr;
    way_t                   dway;
    way_t                   dsel;    // way for dirty and write-back address
    way_vec_t               hit;
    logic                   dirty;
    addr_t                  wb_addr;

    modport ctrl (
        output index, tag, we, vclr, dset, dclr, dway, dsel,
        input  hit, dirty, wb_addr
    );
    modport store (
        input  index, tag, we, vclr, dset, dclr, dway, dsel,
        output hit, dirty, wb_addr
    );
endinterface

// line storage
interface data_if #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
);
    import l2_pkg::*;

    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
    way_vec_t                we;
    logic                    refill; // whole line instead of one word
    word_t                   wword;
    line_t                   rline;
    way_t                    rd_way;
    line_t                   line;
    word_t                   word;

    modport ctrl  (output index, offset, we, refill, wword, rline, rd_way, input line, word);
    modport store (input index, offset, we, refill, wword, rline, rd_way, output line, word);
endinterface

// replacement tree
interface plru_if #(
    parameter int INDEX_WIDTH = 4
);
    import l2_pkg::*;

    logic [INDEX_WIDTH-1:0] index;
    logic                   use_en;
    way_t                   use_way;
    way_t                   victim;

    modport ctrl (output index, use_en, use_way, input victim);
    modport tree (input index, use_en, use_way, output victim);
endinterface

`default_nettype wire

//--- l2_pkg.sv
`default_nettype none

package l2_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int NUM_WAYS       = 4;  // plru tree is built for four
    localparam int ADDR_W         = 16; // word address
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [WORD_W-1:0]                word_t;
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;
    typedef logic [ADDR_W-1:0]                addr_t;
    typedef logic [1:0]                       way_t;
    typedef logic [NUM_WAYS-1:0]              way_vec_t;

    ////////////////////////////////////////
    // opcodes and states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_READ       = 3'd0,
        OP_WRITE      = 3'd1,
        OP_IDX_INIT   = 3'd2, // clear valid, no write-back
        OP_IDX_INV_WB = 3'd3, // way from low address bits
        OP_HIT_INV_WB = 3'd4
    } cpu_op_e;

    typedef enum logic [3:0] {
        ST_IDLE         = 4'd0,
        ST_LOOKUP       = 4'd1,
        ST_OPERATION    = 4'd2,
        ST_CHECK_DIRTY  = 4'd3,
        ST_CHECK_DIRTY1 = 4'd4,
        ST_WRITEBACK    = 4'd5,
        ST_REFILL_REQ   = 4'd6,
        ST_REFILL_WAIT  = 4'd7,
        ST_REFILL_WRITE = 4'd8
    } ctrl_state_e;

endpackage

`default_nettype wire
